// ==== dv/exec_input.txt ====
// Columns, all hex: op a b rep_count expected_value expected_flags; op ffffffff ends the list
// Flags: bit6 OF, bit5 DF, bit4 SF, bit3 ZF, bit2 AF, bit1 PF, bit0 CF
// Single ADD, OR, AND, NOT
00000000 00000001 00000002 00000001 00000003 00000002
00000000 ffffffff 00000001 00000001 00000000 0000000f
00000000 7fffffff 00000001 00000001 80000000 00000056
00000001 0f0f0000 00f000f0 00000001 0fff00f0 00000002
00000004 f0f0f0f0 0f0f0f0f 00000001 00000000 0000000a
00000001 80000000 00000001 00000001 80000001 00000010
00000002 0000ffff 00000000 00000001 ffff0000 00000000
// CMP is b minus a
00000006 12345678 12345678 00000001 00000000 0000000a
00000006 00000005 00000003 00000001 fffffffe 00000015
// BCD add then DAA, low digit then both digits with carry out
00000000 00000019 00000028 00000001 00000041 00000006
00000003 00000041 00000000 00000001 00000047 00000006
00000000 00000058 00000047 00000001 0000009f 00000002
00000003 0000009f 00000000 00000001 00000005 00000007
// DF set by STD, kept by ADD and NOT, cleared by CLD
00000007 00000000 00000000 00000001 00000000 00000020
00000000 00000010 00000020 00000001 00000030 00000022
00000002 ffffffff 00000000 00000001 00000000 00000020
00000005 00000000 00000000 00000001 00000000 00000000
// Repeated ADD with counts 5, 0 and 2
00000000 00000003 00000007 00000005 00000026 00000004
00000000 00000100 00000023 00000000 00000123 00000000
00000000 fffffff0 00000008 00000002 00000000 0000000f
ffffffff 00000000 00000000 00000000 00000000 00000000

// ==== verilog.f ====
verilog/alu_pkg.sv
verilog/exec_pkg.sv
verilog/alu32.sv
verilog/rep_counter.sv
verilog/exec_fsm.sv
verilog/exec_datapath.sv
verilog/exec_unit.sv
dv/exec_checker.sv
dv/tb_exec_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_unit \
		-f verilog.f --Mdir obj_dir -o sim_exec_unit
	./obj_dir/sim_exec_unit > sim.log 2>&1 || echo "test failed" >> sim.log
	cat sim.log
	! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_exec_unit.sv ====
// Run from the project root so dv/exec_input.txt is found; at most 32 vectors, op word ffffffff ends the list
`timescale 1ns/1ps

module tb_exec_unit;

	localparam int CNT_W    = 8;
	localparam int MAX_VECS = 32;
	// Words per vector: op, a, b, count, value, flags
	localparam int WORDS    = 6;

	logic              clk;
	logic              rst_n;
	logic              uop_valid;
	exec_pkg::uop_t    uop;
	logic [CNT_W-1:0]  rep_count;
	logic              busy;
	logic              done;
	alu_pkg::alu_res_t result;
	alu_pkg::eflags_t  eflags;

	// Expected values handed to the checker
	logic [31:0]       exp_value;
	alu_pkg::eflags_t  exp_flags;
	int                exp_cycles;
	int                error_count;
	int                check_count;

	logic [31:0]       vec_mem [0:MAX_VECS*WORDS-1];
	int                num_vecs;
	int                cycle_limit;
	int                cycle_count;

	exec_unit #(.CNT_W(CNT_W)) i_exec_unit (.*);
	exec_checker i_exec_checker (.*);

	// 20 ns clock
	always #10 clk = ~clk;

	// A count of zero still runs one pass
	function automatic int iterations(input logic [31:0] count_word);
		return (count_word[CNT_W-1:0] == '0) ? 1 : int'(count_word[CNT_W-1:0]);
	endfunction

	// -------------------------------------------------------------------
	// Timeout
	// -------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, done never came", cycle_count);
			$display("Errors: %0d, checks: %0d", error_count, check_count);
			$display("test failed");
			$finish;
		end
	end

	// Strobe one micro-op on a falling edge and wait for done
	task automatic run_vector(input int v);
		int base;
		base       = v * WORDS;
		@(negedge clk);
		uop.op     = alu_pkg::alu_op_e'(vec_mem[base][2:0]);
		uop.a      = vec_mem[base+1];
		uop.b      = vec_mem[base+2];
		rep_count  = vec_mem[base+3][CNT_W-1:0];
		exp_value  = vec_mem[base+4];
		exp_flags  = alu_pkg::eflags_t'(vec_mem[base+5][6:0]);
		// Done lands N+1 cycles after the accept edge
		exp_cycles = iterations(vec_mem[base+3]) + 1;
		uop_valid  = 1'b1;
		@(negedge clk);
		uop_valid  = 1'b0;
		while (!done)
			@(negedge clk);
	endtask

	// -------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------
	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		uop_valid   = 1'b0;
		uop         = '0;
		rep_count   = '0;
		exp_value   = '0;
		exp_flags   = '0;
		exp_cycles  = 0;
		num_vecs    = 0;
		cycle_count = 0;
		cycle_limit = 0;
		$readmemh("dv/exec_input.txt", vec_mem);
		while (num_vecs < MAX_VECS && vec_mem[num_vecs*WORDS] != 32'hffffffff)
			num_vecs++;
		// Each vector needs at most count plus three cycles
		cycle_limit = 20;
		for (int v = 0; v < num_vecs; v++)
			cycle_limit += iterations(vec_mem[v*WORDS+3]) + 3;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int v = 0; v < num_vecs; v++)
			run_vector(v);
		repeat (3) @(negedge clk);
		if (num_vecs == 0)
			$display("No vectors read from dv/exec_input.txt");
		$display("Errors: %0d, checks: %0d", error_count, check_count);
		if (error_count == 0 && check_count > 0 && num_vecs > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== dv/exec_checker.sv ====
// Samples on the rising edge; expected values must be stable on the edge that accepts uop_valid
`timescale 1ns/1ps

module exec_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              uop_valid,
	input  logic              busy,
	input  logic              done,
	input  alu_pkg::alu_res_t result,
	input  alu_pkg::eflags_t  eflags,
	input  logic [31:0]       exp_value,
	input  alu_pkg::eflags_t  exp_flags,
	input  int                exp_cycles,
	output int                error_count,
	output int                check_count
);

	int               errors  = 0;
	int               checks  = 0;
	// Micro-op accepted and done not seen yet
	logic             pending = 1'b0;
	// First micro-op accepted
	logic             started = 1'b0;
	int               elapsed = 0;
	logic [31:0]      value_q;
	alu_pkg::eflags_t flags_q;
	int               cycles_q;

	assign error_count = errors;
	assign check_count = checks;

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	// -------------------------------------------------------------------
	// Monitor
	// -------------------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending = 1'b0;
			started = 1'b0;
			elapsed = 0;
		end else begin
			// Reset values hold until the first micro-op
			if (!started) begin
				compare("eflags", 32'd0, {25'd0, eflags});
				compare("result.value", 32'd0, result.value);
			end
			if (pending) begin
				elapsed++;
				if (done) begin
					checks++;
					if (elapsed != cycles_q)
						report($sformatf("done came %0d cycles after accept, expected %0d",
							elapsed, cycles_q));
					if (busy)
						report("busy still high in the done cycle");
					compare("result.value", value_q, result.value);
					compare("result.flags", {25'd0, flags_q}, {25'd0, result.flags});
					compare("eflags", {25'd0, flags_q}, {25'd0, eflags});
					pending = 1'b0;
				end else begin
					if (!busy)
						report("busy low while a micro-op is running");
					if (elapsed >= cycles_q) begin
						report($sformatf("done missing %0d cycles after accept", elapsed));
						pending = 1'b0;
					end
				end
			end else begin
				if (done)
					report("done pulse with no micro-op in flight");
				if (busy)
					report("busy high with no micro-op in flight");
			end
			// Stimulus strobes only while the unit is idle
			if (uop_valid) begin
				pending  = 1'b1;
				started  = 1'b1;
				elapsed  = 0;
				value_q  = exp_value;
				flags_q  = exp_flags;
				cycles_q = exp_cycles;
			end
		end
	end

endmodule

// ==== verilog/exec_unit.sv ====
// Integer execute unit top; 32-bit data fixed, repeat count of zero runs once, no back-pressure
`timescale 1ns/1ps

module exec_unit #(
	parameter int CNT_W = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              uop_valid,
	input  exec_pkg::uop_t    uop,
	input  logic [CNT_W-1:0]  rep_count,
	output logic              busy,
	output logic              done,
	output alu_pkg::alu_res_t result,
	output alu_pkg::eflags_t  eflags
);

	// Control strobes
	logic load;
	logic step;
	logic last;

	// -------------------------------------------------------------------
	// Control
	// -------------------------------------------------------------------
	exec_fsm i_exec_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.uop_valid (uop_valid),
		.last      (last),
		.load      (load),
		.step      (step),
		.busy      (busy),
		.done      (done)
	);

	// Iteration count
	rep_counter #(
		.CNT_W (CNT_W)
	) i_rep_counter (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (load),
		.step     (step),
		.count_in (rep_count),
		.last     (last)
	);

	// -------------------------------------------------------------------
	// Datapath
	// -------------------------------------------------------------------
	exec_datapath i_exec_datapath (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (load),
		.step   (step),
		.uop    (uop),
		.result (result),
		.eflags (eflags)
	);

endmodule

// ==== verilog/exec_datapath.sv ====
// Operand, result and EFLAGS registers; DF changes only on CLD or STD, operands are not reset
`timescale 1ns/1ps

module exec_datapath (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic              step,
	input  exec_pkg::uop_t    uop,
	output alu_pkg::alu_res_t result,
	output alu_pkg::eflags_t  eflags
);

	// Latched micro-op
	alu_pkg::alu_op_e  op_q;
	logic [31:0]       a_q;
	logic [31:0]       b_q;

	alu_pkg::alu_res_t alu_out;
	alu_pkg::eflags_t  flags_next;
	logic              df_write;

	// -------------------------------------------------------------------
	// ALU
	// -------------------------------------------------------------------
	// Forwarded carries for DAA come from the architectural flags
	alu32 i_alu32 (
		.op    (op_q),
		.a     (a_q),
		.b     (b_q),
		.cf_in (eflags.cf),
		.af_in (eflags.af),
		.out   (alu_out)
	);

	// DF survives every op except CLD and STD
	assign df_write = (op_q == alu_pkg::CLD) || (op_q == alu_pkg::STD);

	always_comb begin
		flags_next = alu_out.flags;
		if (!df_write)
			flags_next.df = eflags.df;
	end

	// -------------------------------------------------------------------
	// Operands
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load) begin
			op_q <= uop.op;
			a_q  <= uop.a;
			b_q  <= uop.b;
		end else if (step) begin
			// Each result becomes the next a
			a_q <= alu_out.value;
		end
	end

	// -------------------------------------------------------------------
	// Result and EFLAGS
	// -------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			eflags <= '0;
		end else if (step) begin
			// Result flags carry the retained DF so they match EFLAGS
			result.value <= alu_out.value;
			result.flags <= flags_next;
			eflags       <= flags_next;
		end
	end

	// Registered DAA byte never leaks into the upper bits
	a_daa_upper_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		(step && (op_q == alu_pkg::DAA)) |=> (result.value[31:8] == 24'd0)
	) else $error("DAA result has upper bits set");

endmodule

// ==== verilog/exec_fsm.sv ====
// Execute control; no back-pressure, so uop_valid must stay low while busy is high
`timescale 1ns/1ps

module exec_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic uop_valid,
	input  logic last,
	output logic load,
	output logic step,
	output logic busy,
	output logic done
);

	exec_pkg::exec_state_e state_q;
	exec_pkg::exec_state_e state_d;

	// -------------------------------------------------------------------
	// Next state
	// -------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			exec_pkg::IDLE: begin
				if (uop_valid)
					state_d = exec_pkg::RUN;
			end
			exec_pkg::RUN: begin
				// Leave after the final iteration
				if (step && last)
					state_d = exec_pkg::DONE;
			end
			exec_pkg::DONE: begin
				// Back-to-back micro-op may start here
				state_d = uop_valid ? exec_pkg::RUN : exec_pkg::IDLE;
			end
			default: begin
				state_d = exec_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= exec_pkg::IDLE;
		else
			state_q <= state_d;
	end

	// -------------------------------------------------------------------
	// Outputs
	// -------------------------------------------------------------------
	assign busy = (state_q == exec_pkg::RUN);
	assign step = (state_q == exec_pkg::RUN);
	assign done = (state_q == exec_pkg::DONE);
	// Accept only when not iterating
	assign load = uop_valid && !busy;

	// Upstream has to wait for done before the next strobe
	a_no_valid_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		busy |-> !uop_valid
	) else $error("uop_valid asserted while exec unit busy");

endmodule

// ==== verilog/rep_counter.sv ====
// Repeat iteration counter; a zero count runs once, count width comes from the top level
`timescale 1ns/1ps

module rep_counter #(
	parameter int CNT_W = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             step,
	input  logic [CNT_W-1:0] count_in,
	output logic             last
);

	// Iterations still to run
	logic [CNT_W-1:0] count;

	// -------------------------------------------------------------------
	// Count register
	// -------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			// Treat zero as a single pass
			count <= (count_in == '0) ? CNT_W'(1) : count_in;
		end else if (step) begin
			count <= count - CNT_W'(1);
		end
	end

	// One iteration left
	assign last = (count == CNT_W'(1));

	// Control must stop stepping once the count is used up
	a_no_step_at_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		step |-> (count != '0)
	) else $error("rep_counter stepped with zero iterations left");

endmodule

// ==== verilog/alu32.sv ====
// Combinational 32-bit ALU; CMP computes b minus a, DAA adjusts only the low byte and clears the rest
`timescale 1ns/1ps

module alu32 (
	input  alu_pkg::alu_op_e op,
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	input  logic             cf_in,
	input  logic             af_in,
	output alu_pkg::alu_res_t out
);

	// PF is set for an even number of ones in the low byte
	function automatic logic even_parity(input logic [7:0] v);
		even_parity = ~^v;
	endfunction

	// -------------------------------------------------------------------
	// Arithmetic
	// -------------------------------------------------------------------
	logic [32:0] sum;       // Bit 32 is the carry out
	logic [4:0]  sum_lo;    // Low nibble sum for AF
	logic        add_of;
	logic [32:0] diff;      // Bit 32 is the borrow
	logic [4:0]  diff_lo;   // Low nibble difference for AF
	logic        sub_of;

	assign sum     = {1'b0, a} + {1'b0, b};
	assign sum_lo  = {1'b0, a[3:0]} + {1'b0, b[3:0]};
	// Same-sign operands giving a result of the other sign
	assign add_of  = (a[31] == b[31]) && (sum[31] != a[31]);

	// Compare subtracts a from b
	assign diff    = {1'b0, b} - {1'b0, a};
	assign diff_lo = {1'b0, b[3:0]} - {1'b0, a[3:0]};
	// Operands of different sign and result sign flipped from b
	assign sub_of  = (b[31] != a[31]) && (diff[31] != b[31]);

	// -------------------------------------------------------------------
	// Decimal adjust after addition
	// -------------------------------------------------------------------
	logic       daa_lo_adj;
	logic       daa_hi_adj;
	logic [7:0] daa_step1;
	logic [7:0] daa_byte;

	// Low digit above 9 or a half carry from the previous add
	assign daa_lo_adj = (a[3:0] > 4'd9) || af_in;
	// Whole byte above 99 or a carry from the previous add
	assign daa_hi_adj = (a[7:0] > 8'h99) || cf_in;
	assign daa_step1  = daa_lo_adj ? (a[7:0] + 8'h06) : a[7:0];
	assign daa_byte   = daa_hi_adj ? (daa_step1 + 8'h60) : daa_step1;

	// -------------------------------------------------------------------
	// Result and flag select
	// -------------------------------------------------------------------
	always_comb begin
		// Cleared value and flags unless an operation sets them
		out = '0;
		case (op)
			alu_pkg::ADD: begin
				out.value    = sum[31:0];
				out.flags.of = add_of;
				out.flags.sf = sum[31];
				out.flags.zf = (sum[31:0] == 32'd0);
				out.flags.af = sum_lo[4];
				out.flags.pf = even_parity(sum[7:0]);
				out.flags.cf = sum[32];
			end
			alu_pkg::OR: begin
				out.value    = a | b;
				out.flags.sf = out.value[31];
				out.flags.zf = (out.value == 32'd0);
				out.flags.pf = even_parity(out.value[7:0]);
			end
			alu_pkg::NOT: begin
				// Bitwise invert leaves all flags clear
				out.value = ~a;
			end
			alu_pkg::DAA: begin
				// Upper 24 bits stay zero
				out.value[7:0] = daa_byte;
				out.flags.zf   = (daa_byte == 8'd0);
				out.flags.af   = daa_lo_adj;
				out.flags.pf   = even_parity(daa_byte);
				out.flags.cf   = daa_hi_adj;
			end
			alu_pkg::AND: begin
				out.value    = a & b;
				out.flags.sf = out.value[31];
				out.flags.zf = (out.value == 32'd0);
				out.flags.pf = even_parity(out.value[7:0]);
			end
			alu_pkg::CLD: begin
				// DF cleared along with every other flag
				out.flags.df = 1'b0;
			end
			alu_pkg::CMP: begin
				out.value    = diff[31:0];
				out.flags.of = sub_of;
				out.flags.sf = diff[31];
				out.flags.zf = (diff[31:0] == 32'd0);
				out.flags.af = diff_lo[4];
				out.flags.pf = even_parity(diff[7:0]);
				// Borrow when b is below a
				out.flags.cf = diff[32];
			end
			alu_pkg::STD: begin
				// Only DF set on a zero result
				out.flags.df = 1'b1;
			end
			default: begin
				out = '0;
			end
		endcase
	end

endmodule

// ==== verilog/exec_pkg.sv ====
// Execute unit control types; the micro-op carries one opcode and two fixed 32-bit operands
package exec_pkg;

	// -------------------------------------------------------------------
	// Control states
	// -------------------------------------------------------------------
	// IDLE waits for a strobe, RUN iterates, DONE is the one-cycle pulse
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2
	} exec_state_e;

	// -------------------------------------------------------------------
	// Micro-op
	// -------------------------------------------------------------------
	// Opcode with both source operands
	typedef struct packed {
		alu_pkg::alu_op_e op;
		logic [31:0]      a;
		logic [31:0]      b;
	} uop_t;

endpackage

// ==== verilog/alu_pkg.sv ====
// ALU opcode and flag types; data width fixed at 32 bits, flag layout follows EFLAGS bit order
package alu_pkg;

	// -------------------------------------------------------------------
	// Opcodes
	// -------------------------------------------------------------------
	// Encoding of the three ALU select lines
	typedef enum logic [2:0] {
		ADD = 3'd0,
		OR  = 3'd1,
		NOT = 3'd2,
		DAA = 3'd3,
		AND = 3'd4,
		CLD = 3'd5,
		CMP = 3'd6,
		STD = 3'd7
	} alu_op_e;

	// -------------------------------------------------------------------
	// Flags and result
	// -------------------------------------------------------------------
	// Seven status and control flags with OF in the top bit
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} eflags_t;

	// ALU output as one bundle
	typedef struct packed {
		logic [31:0] value;
		eflags_t     flags;
	} alu_res_t;

endpackage
